// File: compile.f
+incdir+include
rtl/merge_data_pkg.sv
rtl/merge_ctrl_pkg.sv
rtl/lane_fifo.sv
rtl/lane_pipe.sv
rtl/bus_arbiter.sv
rtl/out_skid.sv
rtl/stream_merge.sv
dv/stream_merge_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the stream merger testbench with Verilator and runs it into sim.log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 --timescale 1ns/100ps \
  --top-module stream_merge_tb -f compile.f \
  || { echo "verilator build failed"; exit 1; }

./obj_dir/Vstream_merge_tb > sim.log 2>&1 \
  || echo "simulation exited with an error status" >> sim.log

cat sim.log
grep -q 'Test failures found' sim.log && { echo "RESULT: FAIL"; exit 1; }
grep -q 'All tests passed!' sim.log || { echo "RESULT: FAIL"; exit 1; }
echo "RESULT: PASS"

// File: dv/stream_merge_tb.sv
`include "merge_macros.svh"

module stream_merge_tb
  import merge_data_pkg::*;
  import merge_ctrl_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int ITEMS_PER_LANE = 200;
  localparam int ORDER_ITEMS = 60;  // per lane, sent with the output never stalled
  localparam int RANDOM_STALL_ITEMS = 140;
  localparam int STALL_LOW = 0;
  localparam int STALL_RANDOM = 1;
  localparam int STALL_HIGH = 2;
  localparam int WATCHDOG_CYCLES = ITEMS_PER_LANE * `MERGE_LANES * 20 + 1000;

  logic clk;
  logic rst;
  lane_mask_t in_valid;
  lane_mask_t in_stall;
  payload_t in_data [`MERGE_LANES];
  logic out_valid;
  tagged_t out_data;
  logic out_stall;

  logic [31:0] lfsr_state;
  int sent_cnt [`MERGE_LANES];
  int recv_cnt [`MERGE_LANES];
  int flood_acc [`MERGE_LANES];  // items each lane took since the flood began
  int tag_log [$];
  lane_mask_t stall_seen;
  int value_errors;
  int other_errors;

  stream_merge uut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ------------------------------------------------------------
  // reference model and helpers
  // ------------------------------------------------------------

  function automatic payload_t expected_payload(input int lane, input int seq);
    payload_t p;
    p = {lane_id_t'(lane), 14'(seq)} ^ 16'hc3a5;
    return {p[10:0], p[15:11]};  // rotate so neighbouring items differ in many bits
  endfunction

  function automatic logic next_rand_bit();
    if (lfsr_state[0]) begin
      lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
    end else begin
      lfsr_state = lfsr_state >> 1;
    end
    return lfsr_state[0];
  endfunction

  function automatic bit all_received(input int target);
    for (int l = 0; l < `MERGE_LANES; l++) begin
      if (recv_cnt[l] < target) return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic check_value(input string name, input int expected, input int actual);
    assert (expected == actual) else begin
      value_errors++;
      $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic check_cond(input bit ok, input string what);
    assert (ok) else begin
      other_errors++;
      $display("ERROR: %s", what);
    end
  endtask

  // one clock: count what the producers handed over, then drive the next cycle
  task automatic run_cycle(input bit flood, input int stall_mode, input int target);
    @(posedge clk);
    stall_seen = in_stall;
    for (int l = 0; l < `MERGE_LANES; l++) begin
      if (in_valid[l] && !in_stall[l]) begin
        sent_cnt[l]++;
        flood_acc[l]++;
      end
    end
    @(negedge clk);
    for (int l = 0; l < `MERGE_LANES; l++) begin
      in_valid[l] = (sent_cnt[l] < target) ? (flood ? 1'b1 : next_rand_bit()) : 1'b0;
      in_data[l] = expected_payload(l, sent_cnt[l]);  // held until accepted
    end
    case (stall_mode)
      STALL_RANDOM: out_stall = next_rand_bit();
      STALL_HIGH:   out_stall = 1'b1;
      default:      out_stall = 1'b0;
    endcase
  endtask

  task automatic finish_run();
    $display("summary: %0d value errors, %0d other errors", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  endtask

  // ------------------------------------------------------------
  // output checker
  // ------------------------------------------------------------

  always @(posedge clk) begin
    lane_id_t tag;
    payload_t data;
    if (!rst && out_valid && !out_stall) begin
      tag = out_data[`LANE_W+`PAYLOAD_W-1 -: `LANE_W];
      data = out_data[`PAYLOAD_W-1:0];
      check_cond(recv_cnt[tag] < ITEMS_PER_LANE,
                 $sformatf("lane %0d delivered more than %0d items", tag, ITEMS_PER_LANE));
      check_value($sformatf("order lane %0d item %0d", tag, recv_cnt[tag]),
                  int'(expected_payload(int'(tag), recv_cnt[tag])), int'(data));
      recv_cnt[tag]++;
      tag_log.push_back(int'(tag));
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    other_errors++;
    $display("ERROR: timeout, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    finish_run();
  end

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------

  initial begin
    int mark;
    int cycles;
    lfsr_state = 32'habdc_25d1;
    value_errors = 0;
    other_errors = 0;
    stall_seen = '0;
    for (int l = 0; l < `MERGE_LANES; l++) begin
      sent_cnt[l] = 0;
      recv_cnt[l] = 0;
      flood_acc[l] = 0;
      in_data[l] = '0;
    end
    rst = 1'b0;
    in_valid = '0;
    out_stall = 1'b0;
    #1 rst = 1'b1;

    repeat (4) begin
      @(posedge clk);
      check_value("reset in_stall", 0, int'(in_stall));
      check_value("reset out_valid", 0, int'(out_valid));
    end
    @(negedge clk);
    rst = 1'b0;
    @(posedge clk);
    check_value("after reset in_stall", 0, int'(in_stall));
    check_value("after reset out_valid", 0, int'(out_valid));

    do run_cycle(1'b0, STALL_LOW, ORDER_ITEMS); while (!all_received(ORDER_ITEMS));
    do run_cycle(1'b0, STALL_RANDOM, RANDOM_STALL_ITEMS);
    while (!all_received(RANDOM_STALL_ITEMS));

    // flood every lane against a stalled output until credit runs out
    for (int l = 0; l < `MERGE_LANES; l++) flood_acc[l] = 0;
    cycles = 0;
    do begin
      run_cycle(1'b1, STALL_HIGH, ITEMS_PER_LANE);
      cycles++;
    end while (stall_seen != '1 && cycles < 100);
    check_cond(stall_seen == '1, "not every lane stalled its producer behind a held output");
    for (int l = 0; l < `MERGE_LANES; l++) begin
      check_cond(flood_acc[l] <= `PIPE_DEPTH + 8,
                 $sformatf("lane %0d took %0d items before it stalled", l, flood_acc[l]));
    end
    repeat (`PIPE_DEPTH + 4) run_cycle(1'b1, STALL_HIGH, ITEMS_PER_LANE);

    mark = tag_log.size();
    do run_cycle(1'b1, STALL_LOW, ITEMS_PER_LANE); while (!all_received(ITEMS_PER_LANE));
    repeat (20) run_cycle(1'b0, STALL_LOW, ITEMS_PER_LANE);

    // the first two words after release may predate the full FIFOs
    check_cond(tag_log.size() >= mark + 11, "too few transfers after the stall was released");
    if (tag_log.size() >= mark + 11) begin
      for (int i = mark + 2; i < mark + 10; i++) begin
        check_value("round robin tag", (tag_log[i] + 1) % `MERGE_LANES, tag_log[i+1]);
      end
    end
    for (int l = 0; l < `MERGE_LANES; l++) begin
      check_value($sformatf("lane %0d item count", l), ITEMS_PER_LANE, recv_cnt[l]);
    end
    finish_run();
  end

endmodule

// File: rtl/stream_merge.sv
`include "merge_macros.svh"

module stream_merge import merge_data_pkg::*; import merge_ctrl_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  lane_mask_t in_valid,
  output lane_mask_t in_stall,
  input  payload_t   in_data [`MERGE_LANES],
  output logic       out_valid,
  output tagged_t    out_data,
  input  logic       out_stall
);

  lane_mask_t wr_valid;
  payload_t wr_data [`MERGE_LANES];
  slot_cnt_t free_cnt [`MERGE_LANES];
  lane_mask_t fifo_empty;
  lane_mask_t fifo_rd;
  payload_t head_data [`MERGE_LANES];
  logic bus_valid;
  logic bus_stall;
  tagged_t bus_data;

  // ------------------------------------------------------------
  // lanes
  // ------------------------------------------------------------

  for (genvar i = 0; i < `MERGE_LANES; i++) begin : g_lane
    lane_pipe u_pipe (
      .clk,
      .rst,
      .in_valid (in_valid[i]),
      .in_data  (in_data[i]),
      .free_cnt (free_cnt[i]),
      .in_stall (in_stall[i]),
      .wr_valid (wr_valid[i]),
      .wr_data  (wr_data[i])
    );

    lane_fifo u_fifo (
      .clk,
      .rst,
      .wr_valid  (wr_valid[i]),
      .wr_data   (wr_data[i]),
      .rd        (fifo_rd[i]),
      .head_data (head_data[i]),
      .empty     (fifo_empty[i]),
      .full      (),
      .free_cnt  (free_cnt[i])
    );
  end

  // ------------------------------------------------------------
  // shared bus and output
  // ------------------------------------------------------------

  bus_arbiter u_arb (
    .clk,
    .rst,
    .empty     (fifo_empty),
    .head_data (head_data),
    .bus_stall (bus_stall),
    .rd        (fifo_rd),
    .bus_valid (bus_valid),
    .bus_data  (bus_data)
  );

  out_skid u_skid (
    .clk,
    .rst,
    .bus_valid (bus_valid),
    .bus_data  (bus_data),
    .out_stall (out_stall),
    .bus_stall (bus_stall),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

endmodule

// File: rtl/out_skid.sv
`include "merge_macros.svh"

module out_skid import merge_data_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    bus_valid,
  input  tagged_t bus_data,
  input  logic    out_stall,
  output logic    bus_stall,
  output logic    out_valid,
  output tagged_t out_data
);

  logic skid_valid;
  tagged_t skid_data;
  logic bus_take;

  // the arbiter lets go of its word only while the registered stall is low
  assign bus_take = bus_valid & ~bus_stall;

  assign out_valid = skid_valid | bus_take;
  assign out_data = skid_valid ? skid_data : bus_data;

  // ------------------------------------------------------------
  // stall register and skid entry
  // ------------------------------------------------------------

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bus_stall <= 1'b0;
      skid_valid <= 1'b0;
    end else begin
      bus_stall <= out_stall;
      if (!out_stall) begin
        skid_valid <= 1'b0;  // whatever was shown has moved downstream
      end else if (bus_take) begin
        skid_valid <= 1'b1;
      end
    end
  end

  // a full entry keeps its word until it leaves
  always_ff @(posedge clk) begin
    if (!skid_valid) begin
      skid_data <= bus_data;
    end
  end

  // the stall reaches the arbiter one cycle late, so one entry is enough
  a_skid_no_overrun: assert property (@(posedge clk) disable iff (rst)
    skid_valid |-> !bus_take);

endmodule

// File: rtl/bus_arbiter.sv
`include "merge_macros.svh"

module bus_arbiter import merge_data_pkg::*; import merge_ctrl_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  lane_mask_t empty,
  input  payload_t   head_data [`MERGE_LANES],
  input  logic       bus_stall,
  output lane_mask_t rd,
  output logic       bus_valid,
  output tagged_t    bus_data
);

  arb_state_e state;
  arb_state_e state_n;
  lane_id_t last_lane;  // lane granted most recently
  lane_id_t pick_lane;
  logic pick_valid;
  logic can_load;

  // ------------------------------------------------------------
  // round robin pick starting after the last grant
  // ------------------------------------------------------------

  always_comb begin
    lane_id_t cand;
    pick_valid = 1'b0;
    pick_lane = last_lane;
    for (int i = 1; i <= `MERGE_LANES; i++) begin
      cand = last_lane + lane_id_t'(i);  // wraps back to last_lane on the final step
      if (!pick_valid && !empty[cand]) begin
        pick_valid = 1'b1;
        pick_lane = cand;
      end
    end
  end

  // the register can take a word when it is empty or its word leaves now
  assign can_load = (state == ARB_IDLE) || !bus_stall;

  assign rd = (can_load && pick_valid) ? (lane_mask_t'(1) << pick_lane) : '0;
  assign bus_valid = (state != ARB_IDLE);

  // ------------------------------------------------------------
  // output register FSM
  // ------------------------------------------------------------

  always_comb begin
    state_n = state;
    case (state)
      ARB_IDLE: begin
        if (pick_valid) begin
          state_n = ARB_ISSUE;
        end
      end
      ARB_ISSUE, ARB_HOLD: begin
        if (bus_stall) begin
          state_n = ARB_HOLD;
        end else if (pick_valid) begin
          state_n = ARB_ISSUE;
        end else begin
          state_n = ARB_IDLE;
        end
      end
      default: state_n = ARB_IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= ARB_IDLE;
      last_lane <= lane_id_t'(`MERGE_LANES - 1);  // so lane 0 wins first
    end else begin
      state <= state_n;
      if (|rd) begin
        last_lane <= pick_lane;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (|rd) begin
      bus_data <= {pick_lane, head_data[pick_lane]};
    end
  end

  a_rd_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(rd));

  // a refused word stays on the bus unchanged until the skid side takes it
  a_hold_stable: assert property (@(posedge clk) disable iff (rst)
    bus_valid && bus_stall |=> bus_valid && $stable(bus_data));

endmodule

// File: rtl/lane_pipe.sv
`include "merge_macros.svh"

module lane_pipe import merge_data_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      in_valid,
  input  payload_t  in_data,
  input  slot_cnt_t free_cnt,
  output logic      in_stall,
  output logic      wr_valid,
  output payload_t  wr_data
);

  logic [`PIPE_DEPTH-1:0] vld_q;
  payload_t data_q [`PIPE_DEPTH];
  slot_cnt_t in_flight;  // accepted items that have not reached the FIFO yet
  logic accept;

  assign accept = in_valid & ~in_stall;

  // every item in the chain already owns a FIFO slot
  assign in_stall = (in_flight >= free_cnt);

  assign wr_valid = vld_q[`PIPE_DEPTH-1];
  assign wr_data = data_q[`PIPE_DEPTH-1];

  // ------------------------------------------------------------
  // fixed latency shift chain
  // ------------------------------------------------------------

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[`PIPE_DEPTH-2:0], accept};
    end
  end

  // payloads shift every cycle and the valid bits say which ones count
  always_ff @(posedge clk) begin
    data_q[0] <= in_data;
    for (int i = 1; i < `PIPE_DEPTH; i++) begin
      data_q[i] <= data_q[i-1];
    end
  end

  // ------------------------------------------------------------
  // credit count
  // ------------------------------------------------------------

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      in_flight <= '0;
    end else begin
      case ({accept, wr_valid})
        2'b10:   in_flight <= in_flight + 1'b1;
        2'b01:   in_flight <= in_flight - 1'b1;
        default: in_flight <= in_flight;
      endcase
    end
  end

  a_in_flight_max: assert property (@(posedge clk) disable iff (rst)
    in_flight <= slot_cnt_t'(`PIPE_DEPTH));

endmodule

// File: rtl/lane_fifo.sv
`include "merge_macros.svh"

module lane_fifo import merge_data_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      wr_valid,
  input  payload_t  wr_data,
  input  logic      rd,
  output payload_t  head_data,
  output logic      empty,
  output logic      full,
  output slot_cnt_t free_cnt
);

  localparam int DEPTH = 1 << `FIFO_K;

  payload_t mem [DEPTH];

  // the top bit of each pointer is a wrap bit
  logic [`FIFO_K:0] wr_ptr;
  logic [`FIFO_K:0] rd_ptr;
  logic do_wr;
  logic do_rd;

  assign empty = (wr_ptr == rd_ptr);
  assign full = (wr_ptr == {~rd_ptr[`FIFO_K], rd_ptr[`FIFO_K-1:0]});
  assign head_data = mem[rd_ptr[`FIFO_K-1:0]];  // head is valid whenever not empty

  assign do_wr = wr_valid & ~full;
  assign do_rd = rd & ~empty;

  // ------------------------------------------------------------
  // pointers and free-slot count
  // ------------------------------------------------------------

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      free_cnt <= slot_cnt_t'(DEPTH);  // all slots free out of reset
    end else begin
      case ({do_wr, do_rd})
        2'b10:   free_cnt <= free_cnt - 1'b1;
        2'b01:   free_cnt <= free_cnt + 1'b1;
        default: free_cnt <= free_cnt;
      endcase
    end
  end

  // ------------------------------------------------------------
  // storage
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr[`FIFO_K-1:0]] <= wr_data;
    end
  end

  // the credit count in the lane pipe must keep writes off a full FIFO
  a_no_wr_full: assert property (@(posedge clk) disable iff (rst)
    wr_valid |-> !full);

  // the arbiter only strobes lanes that hold a word
  a_no_rd_empty: assert property (@(posedge clk) disable iff (rst)
    rd |-> !empty);

endmodule

// File: rtl/merge_ctrl_pkg.sv
`include "merge_macros.svh"

package merge_ctrl_pkg;

  // one bit per lane for empty flags, read strobes and grants
  typedef logic [`MERGE_LANES-1:0] lane_mask_t;

  // ------------------------------------------------------------
  // output register state of the arbiter
  // ------------------------------------------------------------

  typedef enum logic [1:0] {
    ARB_IDLE,   // output register holds nothing
    ARB_ISSUE,  // a freshly read word is on the bus
    ARB_HOLD    // the word on the bus was refused and is kept
  } arb_state_e;

endpackage

// File: rtl/merge_data_pkg.sv
`include "merge_macros.svh"

package merge_data_pkg;

  // ------------------------------------------------------------
  // words carried by the lanes and the shared bus
  // ------------------------------------------------------------

  typedef logic [`PAYLOAD_W-1:0] payload_t;

  typedef logic [`LANE_W-1:0] lane_id_t;

  // the lane number sits above the payload on the shared bus
  typedef logic [`LANE_W+`PAYLOAD_W-1:0] tagged_t;

  // ------------------------------------------------------------
  // counts
  // ------------------------------------------------------------

  typedef logic [`CNT_W-1:0] slot_cnt_t;  // free FIFO slots or items in flight

endpackage

// File: include/merge_macros.svh
`ifndef MERGE_MACROS_SVH
`define MERGE_MACROS_SVH

// lane count and the width of a lane number go together
`define MERGE_LANES 4
`define LANE_W      2

`define PAYLOAD_W   16

// every item spends exactly this many cycles in its lane pipeline
`define PIPE_DEPTH  6

// each lane FIFO holds 2**FIFO_K words
`define FIFO_K      3

// one extra bit so a count can reach the full FIFO depth
`define CNT_W       (`FIFO_K + 1)

`endif
